//--- sdio_host_top.f
hw/sdio_clk_pkg.sv
hw/sdio_cmd_pkg.sv
hw/sdio_clk_gen.sv
hw/sdio_crc7.sv
hw/sdio_cmd_tx.sv
hw/sdio_host_top.sv
testbench/sdio_host_assertions.sv
testbench/sdio_host_tb.sv

//--- Bender.yml
package:
  name: sdio_host

sources:
  - files:
      - hw/sdio_clk_pkg.sv
      - hw/sdio_cmd_pkg.sv
      - hw/sdio_clk_gen.sv
      - hw/sdio_crc7.sv
      - hw/sdio_cmd_tx.sv
      - hw/sdio_host_top.sv
  - target: test
    files:
      - testbench/sdio_host_assertions.sv
      - testbench/sdio_host_tb.sv

//--- testbench/sdio_host_tb.sv
// ---------------------------------------------------------------------------
// SD host testbench
// LFSR commands at every speed mode, captured CMD frames compared with a
// bit-serial CRC7 frame model, card clock periods counted in system cycles
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sdio_host_tb
   import sdio_clk_pkg::*, sdio_cmd_pkg::*;
();

   localparam int N_DS  = 8;
   localparam int N_ID  = 2;
   localparam int N_HS  = 6;
   localparam int N_MIX = 6;
   // Four settle rises per measured mode, frames weighted by card clock period
   localparam int CLK_CYC = 5 * (500 + 4 + 2 + 2);
   localparam int FRM_CYC = (FRAME_LEN + 4) * (N_ID * 500 + (N_DS + 1 + N_MIX) * 4 + N_HS * 2);
   localparam int LIMIT   = (CLK_CYC + FRM_CYC) * 12 / 10;

   logic                 i_clk100M;
   logic                 i_rst_n;
   speed_mode_e          i_speed_mode;
   logic                 i_cmd_start;
   logic [CMD_IDX_W-1:0] i_cmd_index;
   logic [CMD_ARG_W-1:0] i_cmd_arg;
   logic                 o_sd_clk;
   logic                 o_sd_cmd;
   logic                 o_sd_cmd_oe;
   logic                 o_cmd_busy;
   logic                 o_cmd_done;

   logic [31:0]          lfsr_state = 32'h352cd6a3;
   logic [FRAME_LEN-1:0] cap_frame;
   logic                 prev_sd_clk = 1'b0;
   int cyc = 0;
   int last_rise = 0;
   int rise_period = 0;
   int rise_cnt = 0;
   int cap_bits = 0;
   int done_cnt = 0;
   int idle_err = 0;
   int accepted = 0;
   int err_cnt = 0;
   int n_tests = 0;
   int n_failed = 0;

   sdio_host_top dut_i (
      .i_clk100M    (i_clk100M),
      .i_rst_n      (i_rst_n),
      .i_speed_mode (i_speed_mode),
      .i_cmd_start  (i_cmd_start),
      .i_cmd_index  (i_cmd_index),
      .i_cmd_arg    (i_cmd_arg),
      .o_sd_clk     (o_sd_clk),
      .o_sd_cmd     (o_sd_cmd),
      .o_sd_cmd_oe  (o_sd_cmd_oe),
      .o_cmd_busy   (o_cmd_busy),
      .o_cmd_done   (o_cmd_done)
   );

   initial
   begin
      i_clk100M = 1'b0;
      forever #5 i_clk100M = ~i_clk100M;
   end

   // Cycle count and run limit
   always @(posedge i_clk100M)
   begin
      cyc = cyc + 1;
      if (cyc > LIMIT)
      begin
         $display("Timeout: run went past %0d cycles", LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   // Monitor, all pins sampled mid cycle
   always @(negedge i_clk100M)
   begin
      if (o_sd_clk && !prev_sd_clk)
      begin
         rise_period = cyc - last_rise;
         last_rise   = cyc;
         rise_cnt    = rise_cnt + 1;
         // Card side view of CMD, taken on the card clock rise
         if (o_sd_cmd_oe)
         begin
            cap_frame = {cap_frame[FRAME_LEN-2:0], o_sd_cmd};
            cap_bits  = cap_bits + 1;
         end
      end
      prev_sd_clk = o_sd_clk;
      if (i_rst_n && !o_sd_cmd_oe && o_sd_cmd !== 1'b1)
         idle_err = idle_err + 1;
      if (o_cmd_done)
         done_cnt = done_cnt + 1;
   end

   // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v          = {v[30:0], fb};
      end
      return v;
   endfunction

   // Start 0, transmission 1, index, argument, CRC7 over those 40 bits, end 1
   function automatic logic [FRAME_LEN-1:0] frame_model(input logic [5:0] idx,
                                                        input logic [31:0] arg);
      logic [39:0] hdr;
      logic [6:0]  crc;
      logic        fb;
      int          i;
      hdr = {2'b01, idx, arg};
      crc = '0;
      for (i = 39; i >= 0; i--)
      begin
         fb  = hdr[i] ^ crc[6];
         crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      end
      return {hdr, crc, 1'b1};
   endfunction

   task automatic end_test(input string name, input int errs_before);
      n_tests = n_tests + 1;
      if (err_cnt == errs_before)
         $display("PASS  %s", name);
      else
      begin
         $display("FAIL  %s", name);
         n_failed = n_failed + 1;
      end
   endtask

   task automatic set_mode(input speed_mode_e mode);
      @(posedge i_clk100M);
      i_speed_mode <= mode;
      repeat (2) @(posedge i_clk100M);
   endtask

   task automatic check_period(input string name, input speed_mode_e mode, input int exp_per);
      int errs_before;
      int rises;
      errs_before = err_cnt;
      set_mode(mode);
      rises = rise_cnt;
      // First periods after a switch can be short
      wait (rise_cnt >= rises + 4);
      if (rise_period != exp_per)
      begin
         $display("CHECK FAILED %s expected %0d actual %0d", name, exp_per, rise_period);
         err_cnt = err_cnt + 1;
      end
      end_test(name, errs_before);
   endtask

   task automatic send_frame(input string name, input logic [5:0] idx,
                             input logic [31:0] arg, input bit busy_start);
      logic [FRAME_LEN-1:0] exp_frame;
      int                   errs_before;
      int                   done_before;
      exp_frame   = frame_model(idx, arg);
      errs_before = err_cnt;
      done_before = done_cnt;
      cap_bits    = 0;
      @(posedge i_clk100M);
      i_cmd_start <= 1'b1;
      i_cmd_index <= idx;
      i_cmd_arg   <= arg;
      @(posedge i_clk100M);
      i_cmd_start <= 1'b0;
      accepted = accepted + 1;
      if (busy_start)
      begin
         repeat (3) @(negedge i_clk100M);
         if (!o_cmd_busy)
         begin
            $display("%s: busy was low when the second start was issued", name);
            err_cnt = err_cnt + 1;
         end
         // Different command, must be dropped
         @(posedge i_clk100M);
         i_cmd_start <= 1'b1;
         i_cmd_index <= ~idx;
         i_cmd_arg   <= ~arg;
         @(posedge i_clk100M);
         i_cmd_start <= 1'b0;
      end
      do
         @(negedge i_clk100M);
      while (!o_cmd_done);
      // Busy drops together with the done pulse
      if (o_cmd_busy)
      begin
         $display("%s: busy still high during the done pulse", name);
         err_cnt = err_cnt + 1;
      end
      repeat (4) @(negedge i_clk100M);
      if (cap_bits != FRAME_LEN || cap_frame !== exp_frame)
      begin
         $display("CHECK FAILED %s expected %0d bits %h actual %0d bits %h",
                  name, FRAME_LEN, exp_frame, cap_bits, cap_frame);
         err_cnt = err_cnt + 1;
      end
      if (done_cnt != done_before + 1)
      begin
         $display("CHECK FAILED %s expected %0d done pulses actual %0d",
                  name, 1, done_cnt - done_before);
         err_cnt = err_cnt + 1;
      end
      end_test(name, errs_before);
   endtask

   task automatic send_random(input string name, input bit busy_start);
      logic [5:0]  idx;
      logic [31:0] arg;
      idx = 6'(lfsr_bits(6));
      arg = lfsr_bits(32);
      send_frame(name, idx, arg, busy_start);
   endtask

   initial
   begin
      int          k;
      int          errs_before;
      logic [1:0]  sel;
      speed_mode_e mode;
      i_rst_n      <= 1'b0;
      i_speed_mode <= SPD_ID_200K;
      i_cmd_start  <= 1'b0;
      i_cmd_index  <= '0;
      i_cmd_arg    <= '0;
      repeat (2) @(posedge i_clk100M);
      i_rst_n <= 1'b1;

      check_period("clk_period_200k", SPD_ID_200K, 500);
      check_period("clk_period_25m", SPD_DS_25M, 4);
      check_period("clk_period_50m", SPD_HS_50M, 2);
      check_period("clk_period_unknown", speed_mode_e'(4'd11), 2);

      set_mode(SPD_DS_25M);
      // CMD0 with a zero argument carries the well known CRC 7'h4a
      errs_before = err_cnt;
      if (frame_model(6'd0, 32'd0) !== 48'h40_0000_0000_95)
      begin
         $display("CHECK FAILED crc7_cmd0 expected %h actual %h",
                  48'h40_0000_0000_95, frame_model(6'd0, 32'd0));
         err_cnt = err_cnt + 1;
      end
      end_test("crc7_cmd0", errs_before);
      send_frame("frame_25m_cmd0", 6'd0, 32'd0, 1'b0);
      for (k = 1; k < N_DS; k++)
         send_random($sformatf("frame_25m_%0d", k), 1'b0);
      set_mode(SPD_ID_200K);
      for (k = 0; k < N_ID; k++)
         send_random($sformatf("frame_200k_%0d", k), 1'b0);
      set_mode(SPD_HS_50M);
      for (k = 0; k < N_HS; k++)
         send_random($sformatf("frame_50m_%0d", k), 1'b0);
      set_mode(SPD_DS_25M);
      send_random("start_while_busy", 1'b1);

      // Random modes, codes above 2 included
      for (k = 0; k < N_MIX; k++)
      begin
         sel  = 2'(lfsr_bits(2));
         mode = (sel == 2'd0) ? SPD_DS_25M :
                (sel == 2'd1) ? SPD_HS_50M : speed_mode_e'(4'd12 + sel);
         set_mode(mode);
         send_random($sformatf("frame_mixed_%0d", k), 1'b0);
      end

      errs_before = err_cnt;
      if (idle_err != 0)
      begin
         $display("CHECK FAILED idle_line expected 0 idle violations actual %0d", idle_err);
         err_cnt = err_cnt + 1;
      end
      if (done_cnt != accepted)
      begin
         $display("CHECK FAILED idle_line expected %0d done pulses actual %0d",
                  accepted, done_cnt);
         err_cnt = err_cnt + 1;
      end
      end_test("idle_line", errs_before);

      $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion errors",
               n_tests, n_tests - n_failed, n_failed, err_cnt, dut_i.assert_i.n_fail);
      if (err_cnt == 0 && n_failed == 0 && dut_i.assert_i.n_fail == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- testbench/sdio_host_assertions.sv
// ---------------------------------------------------------------------------
// SD host pin assertions
// Bound into the host top level, checks the CMD line against the card clock
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sdio_host_assertions
(
   input logic i_clk100M,
   input logic i_rst_n,
   input logic i_sd_clk,
   input logic i_sd_cmd,
   input logic i_sd_cmd_oe,
   input logic i_cmd_done
);

   // Count of failed assertions
   int n_fail = 0;

   // Done is a one cycle strobe
   done_one_cycle: assert property (@(posedge i_clk100M) disable iff (!i_rst_n)
      i_cmd_done |=> !i_cmd_done)
   else
   begin
      $error("Command done stayed high for more than one cycle");
      n_fail++;
   end

   // Released line idles high
   idle_high: assert property (@(posedge i_clk100M) disable iff (!i_rst_n)
      !i_sd_cmd_oe |-> i_sd_cmd)
   else
   begin
      $error("CMD low while its output enable is low");
      n_fail++;
   end

   // CMD only moves together with a card clock fall
   cmd_on_fall: assert property (@(posedge i_clk100M) disable iff (!i_rst_n)
      !$stable(i_sd_cmd) |-> $fell(i_sd_clk))
   else
   begin
      $error("CMD changed away from a card clock falling edge");
      n_fail++;
   end

endmodule

bind sdio_host_top sdio_host_assertions assert_i (
   .i_clk100M   (i_clk100M),
   .i_rst_n     (i_rst_n),
   .i_sd_clk    (o_sd_clk),
   .i_sd_cmd    (o_sd_cmd),
   .i_sd_cmd_oe (o_sd_cmd_oe),
   .i_cmd_done  (o_cmd_done)
);

//--- hw/sdio_host_top.sv
// ---------------------------------------------------------------------------
// SD host clock and command path
// Card clock generator feeding the command transmitter
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sdio_host_top
   import sdio_clk_pkg::*, sdio_cmd_pkg::*;
(
   input  logic                 i_clk100M,
   input  logic                 i_rst_n,
   input  speed_mode_e          i_speed_mode,
   input  logic                 i_cmd_start,
   input  logic [CMD_IDX_W-1:0] i_cmd_index,
   input  logic [CMD_ARG_W-1:0] i_cmd_arg,
   output logic                 o_sd_clk,
   output logic                 o_sd_cmd,
   output logic                 o_sd_cmd_oe,
   output logic                 o_cmd_busy,
   output logic                 o_cmd_done
);

   // Card clock falling edge strobe
   logic w_clk_fall;

   sdio_clk_gen clk_gen_i (
      .i_clk100M    (i_clk100M),
      .i_rst_n      (i_rst_n),
      .i_speed_mode (i_speed_mode),
      .o_sd_clk     (o_sd_clk),
      .o_clk_fall   (w_clk_fall)
   );

   // CMD changes on card clock falls, the card samples on rises
   sdio_cmd_tx cmd_tx_i (
      .i_clk100M   (i_clk100M),
      .i_rst_n     (i_rst_n),
      .i_clk_fall  (w_clk_fall),
      .i_cmd_start (i_cmd_start),
      .i_cmd_index (i_cmd_index),
      .i_cmd_arg   (i_cmd_arg),
      .o_sd_cmd    (o_sd_cmd),
      .o_sd_cmd_oe (o_sd_cmd_oe),
      .o_busy      (o_cmd_busy),
      .o_done      (o_cmd_done)
   );

endmodule

//--- hw/sdio_cmd_tx.sv
// ---------------------------------------------------------------------------
// SD command transmitter
// Sends start, transmission, index, argument, CRC7 and end bits on CMD,
// one bit per card clock falling edge
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sdio_cmd_tx
   import sdio_cmd_pkg::*;
(
   input  logic                 i_clk100M,
   input  logic                 i_rst_n,
   input  logic                 i_clk_fall,
   input  logic                 i_cmd_start,
   input  logic [CMD_IDX_W-1:0] i_cmd_index,
   input  logic [CMD_ARG_W-1:0] i_cmd_arg,
   output logic                 o_sd_cmd,
   output logic                 o_sd_cmd_oe,
   output logic                 o_busy,
   output logic                 o_done
);

   cmd_state_e             r_state;
   logic [HDR_LEN-1:0]     r_shift;
   logic [FRAME_CNT_W-1:0] r_bit_cnt;
   logic                   w_start_ok;
   logic                   w_send;
   logic                   w_in_hdr;
   logic [2:0]             w_crc_sel;
   logic [CRC7_W-1:0]      w_crc;
   logic                   w_tx_bit;

   // Starts are only taken while idle, others are dropped
   assign w_start_ok = (r_state == ST_IDLE) & i_cmd_start;
   assign w_send     = (r_state == ST_SEND) & i_clk_fall;
   assign w_in_hdr   = (r_bit_cnt < FRAME_CNT_W'(HDR_LEN));

   // CRC bit 6 goes out first at bit 40, bit 0 last at bit 46
   assign w_crc_sel = 3'(HDR_LEN + CRC7_W - 1 - r_bit_cnt);

   // Next bit on the line: header, then CRC, then end bit
   always_comb
   begin
      if (w_in_hdr)
         w_tx_bit = r_shift[HDR_LEN-1];
      else if (r_bit_cnt < FRAME_CNT_W'(HDR_LEN + CRC7_W))
         w_tx_bit = w_crc[w_crc_sel];
      else
         w_tx_bit = 1'b1;
   end

   // Header bits enter the CRC as they leave on CMD
   sdio_crc7 crc7_i (
      .i_clk100M  (i_clk100M),
      .i_rst_n    (i_rst_n),
      .i_clear    (w_start_ok),
      .i_shift_en (w_send & w_in_hdr),
      .i_bit      (r_shift[HDR_LEN-1]),
      .o_crc      (w_crc)
   );

   // Header shift register, MSB first
   always_ff @(posedge i_clk100M)
   begin
      if (w_start_ok)
         r_shift <= {1'b0, 1'b1, i_cmd_index, i_cmd_arg};
      else if (w_send)
         r_shift <= {r_shift[HDR_LEN-2:0], 1'b0};
   end

   // Frame FSM and line drivers
   always_ff @(posedge i_clk100M or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         r_state     <= ST_IDLE;
         r_bit_cnt   <= '0;
         o_sd_cmd    <= 1'b1;
         o_sd_cmd_oe <= 1'b0;
         o_busy      <= 1'b0;
         o_done      <= 1'b0;
      end
      else
      begin
         o_done <= 1'b0;
         case (r_state)
            ST_IDLE:
            begin
               if (i_cmd_start)
               begin
                  r_bit_cnt <= '0;
                  o_busy    <= 1'b1;
                  r_state   <= ST_SEND;
               end
            end
            ST_SEND:
            begin
               // Drive the first bit on the first fall after the start
               if (i_clk_fall)
               begin
                  o_sd_cmd_oe <= 1'b1;
                  o_sd_cmd    <= w_tx_bit;
                  r_bit_cnt   <= r_bit_cnt + 1'b1;
                  if (r_bit_cnt == FRAME_CNT_W'(FRAME_LEN - 1))
                     r_state <= ST_DONE;
               end
            end
            ST_DONE:
            begin
               // End bit has been sampled, release the line
               if (i_clk_fall)
               begin
                  o_sd_cmd_oe <= 1'b0;
                  o_sd_cmd    <= 1'b1;
                  o_busy      <= 1'b0;
                  o_done      <= 1'b1;
                  r_state     <= ST_IDLE;
               end
            end
            default:
               r_state <= ST_IDLE;
         endcase
      end
   end

endmodule

//--- hw/sdio_crc7.sv
// ---------------------------------------------------------------------------
// Serial CRC7 generator
// One message bit per enabled cycle, remainder of x^7 + x^3 + 1
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sdio_crc7
   import sdio_cmd_pkg::*;
(
   input  logic              i_clk100M,
   input  logic              i_rst_n,
   input  logic              i_clear,
   input  logic              i_shift_en,
   input  logic              i_bit,
   output logic [CRC7_W-1:0] o_crc
);

   logic w_feedback;

   // Incoming bit against the register MSB
   assign w_feedback = i_bit ^ o_crc[CRC7_W-1];

   always_ff @(posedge i_clk100M or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         o_crc <= '0;
      end
      else if (i_clear)
      begin
         o_crc <= '0;
      end
      else if (i_shift_en)
      begin
         // Shift left and fold the polynomial in on feedback
         o_crc <= {o_crc[CRC7_W-2:0], 1'b0} ^ (w_feedback ? CRC7_POLY : '0);
      end
   end

endmodule

//--- hw/sdio_clk_gen.sv
// ---------------------------------------------------------------------------
// SD card clock generator
// Divides the 100 MHz clock to 200 kHz, 25 MHz or 50 MHz and flags the
// system clock edge on which the card clock falls
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module sdio_clk_gen
   import sdio_clk_pkg::*;
(
   input  logic        i_clk100M,
   input  logic        i_rst_n,
   input  speed_mode_e i_speed_mode,
   output logic        o_sd_clk,
   output logic        o_clk_fall
);

   speed_mode_e          r_speed_mode;
   logic [DIV_CNT_W-1:0] r_div_cnt;
   logic [DIV_CNT_W-1:0] w_limit;
   logic                 w_wrap;

   // Speed request is sampled once per system clock
   always_ff @(posedge i_clk100M or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         r_speed_mode <= SPD_ID_200K;
      end
      else
      begin
         r_speed_mode <= i_speed_mode;
      end
   end

   // Last count of a half period for the active mode
   always_comb
   begin
      case (r_speed_mode)
         SPD_ID_200K: w_limit = DIV_CNT_W'(HALF_ID - 1);
         SPD_DS_25M:  w_limit = DIV_CNT_W'(HALF_DS - 1);
         SPD_HS_50M:  w_limit = DIV_CNT_W'(HALF_HS - 1);
         // Unknown codes fall back to high speed
         default:     w_limit = DIV_CNT_W'(HALF_HS - 1);
      endcase
   end

   // Compare with >= so a switch to a shorter limit wraps at once
   assign w_wrap = (r_div_cnt >= w_limit);

   // Divider counter and card clock register
   always_ff @(posedge i_clk100M or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         r_div_cnt <= '0;
         o_sd_clk  <= 1'b0;
      end
      else if (w_wrap)
      begin
         r_div_cnt <= '0;
         o_sd_clk  <= ~o_sd_clk;
      end
      else
      begin
         r_div_cnt <= r_div_cnt + 1'b1;
      end
   end

   // High in the cycle whose closing edge takes the card clock low,
   // so a register enabled by it changes together with the pin
   assign o_clk_fall = w_wrap & o_sd_clk;

endmodule

//--- hw/sdio_cmd_pkg.sv
// ---------------------------------------------------------------------------
// SD command frame definitions
// Field widths, bit positions and transmitter states of the 48-bit
// command frame sent on the CMD line
// ---------------------------------------------------------------------------
package sdio_cmd_pkg;

   localparam int unsigned CMD_IDX_W   = 6;
   localparam int unsigned CMD_ARG_W   = 32;
   localparam int unsigned CRC7_W      = 7;
   localparam int unsigned FRAME_LEN   = 48;
   localparam int unsigned FRAME_CNT_W = 6;

   // Start, transmission, index and argument bits covered by the CRC
   localparam int unsigned HDR_LEN = CMD_IDX_W + CMD_ARG_W + 2;

   // x^7 + x^3 + 1
   localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEND,
      ST_DONE
   } cmd_state_e;

endpackage

//--- hw/sdio_clk_pkg.sv
// ---------------------------------------------------------------------------
// SD card clock definitions
// Speed mode codes and divider limits for the card clock generator,
// all counted in cycles of the 100 MHz system clock
// ---------------------------------------------------------------------------
package sdio_clk_pkg;

   // Width of the speed mode field
   localparam int unsigned SPEED_W = 4;

   // Speed mode codes, any code not listed runs at 50 MHz
   typedef enum logic [SPEED_W-1:0] {
      SPD_ID_200K = 4'd0,
      SPD_DS_25M  = 4'd1,
      SPD_HS_50M  = 4'd2
   } speed_mode_e;

   // System clock cycles per card clock half period
   localparam int unsigned HALF_ID = 250;
   localparam int unsigned HALF_DS = 2;
   localparam int unsigned HALF_HS = 1;

   // Divider counter width, large enough for the 200 kHz limit
   localparam int unsigned DIV_CNT_W = 9;

endpackage
